/* csa_defs.svh */
`ifndef CSA_DEFS_SVH
`define CSA_DEFS_SVH

// Bus word width of the register window and of both FIFOs.
`define CSA_DATA_W 32

// Number of calculation units in the farm.
`define CSA_UNIT_NUM 4

`define CSA_ADDR_BITS 10

// Job and result lengths in bus words.
`define CSA_IN_WORDS 5
`define CSA_OUT_WORDS 7

`define CSA_KEY_W 48

`endif

/* csa_job_pkg.sv */
`include "csa_defs.svh"

package csa_job_pkg;

	typedef struct packed {
		logic [`CSA_DATA_W-1:0] times_start;
		logic [`CSA_DATA_W-1:0] times;
		logic [`CSA_KEY_W-1:0] key_in;
		logic [`CSA_DATA_W-1:0] block;
	} job_t;

	typedef struct packed {
		logic [2*`CSA_DATA_W-1:0] calc_out;
		job_t job;
	} result_t;

	// Word idx of a result as it travels on the bus. Words 0 to 4 are the job itself.
	function automatic logic [`CSA_DATA_W-1:0] res_word(input result_t r, input int unsigned idx);
		logic [`CSA_DATA_W-1:0] w;
		case (idx)
			0: w = r.job.block;
			1: w = r.job.key_in[`CSA_DATA_W-1:0];
			2: w = {{(2*`CSA_DATA_W-`CSA_KEY_W){1'b0}}, r.job.key_in[`CSA_KEY_W-1:`CSA_DATA_W]};
			3: w = r.job.times;
			4: w = r.job.times_start;
			5: w = r.calc_out[`CSA_DATA_W-1:0];
			default: w = r.calc_out[2*`CSA_DATA_W-1:`CSA_DATA_W];
		endcase
		return w;
	endfunction

endpackage

/* csa_reg_pkg.sv */
`include "csa_defs.svh"

package csa_reg_pkg;

	typedef logic [$clog2(`CSA_UNIT_NUM)-1:0] unit_idx_t;

	// Register map of the window, one word per address.
	typedef enum logic [`CSA_ADDR_BITS-1:0] {
		CHANNEL = 'd0,
		IN_VALID = 'd1,
		IN_DATA_0, IN_DATA_1, IN_DATA_2, IN_DATA_3, IN_DATA_4,
		OUT_VALID = 'd7,
		OUT_DATA_0, OUT_DATA_1, OUT_DATA_2, OUT_DATA_3,
		OUT_DATA_4, OUT_DATA_5, OUT_DATA_6
	} reg_addr_e;

	// Copy of the last record seen on the current channel.
	typedef struct packed {
		logic valid;
		logic [`CSA_OUT_WORDS-1:0][`CSA_DATA_W-1:0] words;
	} snap_t;

endpackage

/* csa_calc_if.sv */
`timescale 1ns/1ps

interface csa_calc_if
	import csa_job_pkg::*;
();

	logic job_valid;
	logic job_ready;
	job_t job;

	logic res_valid;
	logic res_ready;
	result_t res;

	modport loader (output job_valid, output job, input job_ready);

	modport unit (input job_valid, input job, output job_ready,
		output res_valid, output res, input res_ready);

	modport drain (input res_valid, input res, output res_ready);

endinterface

/* csa_slot.sv */
`timescale 1ns/1ps

module csa_slot #(
	parameter type payload_t = logic
) (
	input logic axi_mm_clk,
	input logic rst_n,
	input logic wr_i,
	input payload_t wr_data_i,
	output logic full_o,
	input logic rd_i,
	output payload_t rd_data_o
);

	payload_t data_q;
	logic full_q;

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			full_q <= 1'b0;
		end else if (wr_i) begin
			full_q <= 1'b1;
		end else if (rd_i) begin
			full_q <= 1'b0;
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (wr_i) begin
			data_q <= wr_data_i;
		end
	end

	assign full_o = full_q;
	assign rd_data_o = data_q;

	// The writer in the parent has to respect full_o, or a payload is overwritten.
	a_no_overwrite: assert property (@(posedge axi_mm_clk) disable iff (!rst_n)
		full_q |-> !wr_i);

endmodule

/* csa_calc_unit.sv */
`timescale 1ns/1ps
`include "csa_defs.svh"

module csa_calc_unit
	import csa_job_pkg::*;
(
	input logic axi_mm_clk,
	input logic rst_n,
	csa_calc_if.unit calc
);

	localparam int STATE_W = 2 * `CSA_DATA_W;

	job_t job_w;
	result_t res_w;
	logic job_full;
	logic res_full;
	logic busy_q;
	logic [`CSA_DATA_W-1:0] round_q;
	logic [STATE_W-1:0] state_q;
	logic last_round;
	logic finish;

	csa_slot #(.payload_t(job_t)) u_job_slot (
		.axi_mm_clk(axi_mm_clk),
		.rst_n(rst_n),
		.wr_i(calc.job_valid && calc.job_ready),
		.wr_data_i(calc.job),
		.full_o(job_full),
		.rd_i(finish),
		.rd_data_o(job_w)
	);

	csa_slot #(.payload_t(result_t)) u_res_slot (
		.axi_mm_clk(axi_mm_clk),
		.rst_n(rst_n),
		.wr_i(finish),
		.wr_data_i(res_w),
		.full_o(res_full),
		.rd_i(calc.res_valid && calc.res_ready),
		.rd_data_o(calc.res)
	);

	assign calc.job_ready = !job_full;
	assign calc.res_valid = res_full;

	// The job stays in its slot until the result can leave, which back-pressures the loader.
	assign last_round = (round_q == job_w.times);
	assign finish = busy_q && last_round && !res_full;
	assign res_w = '{calc_out: state_q, job: job_w};

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			busy_q <= 1'b0;
			round_q <= '0;
		end else if (!busy_q && job_full) begin
			busy_q <= 1'b1;
			round_q <= '0;
		end else if (busy_q && !last_round) begin
			round_q <= round_q + 1'b1;
		end else if (finish) begin
			busy_q <= 1'b0;
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (!busy_q && job_full) begin
			state_q <= {{(STATE_W-`CSA_KEY_W){1'b0}}, job_w.key_in} ^ {job_w.block, job_w.block};
		end else if (busy_q && !last_round) begin
			state_q <= {state_q[STATE_W-2:0], state_q[STATE_W-1]}
				^ {{`CSA_DATA_W{1'b0}}, job_w.times_start + round_q};
		end
	end

endmodule

/* csa_job_loader.sv */
`timescale 1ns/1ps
`include "csa_defs.svh"

module csa_job_loader
	import csa_job_pkg::*;
	import csa_reg_pkg::*;
(
	input logic axi_mm_clk,
	input logic rst_n,
	input logic in_ready_i,
	output logic in_ren_o,
	input logic [`CSA_DATA_W-1:0] in_rdata_i,
	csa_calc_if.loader calc [`CSA_UNIT_NUM],
	output logic disp_o,
	output unit_idx_t disp_unit_o,
	output job_t disp_job_o
);

	typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_SCAN, ST_SEND} state_e;

	state_e state_q;
	logic [2:0] pulse_cnt_q;
	logic [2:0] word_cnt_q;
	logic take_q;
	unit_idx_t scan_q;
	unit_idx_t cur_q;
	logic valid_q;
	job_t job_q;
	logic [`CSA_UNIT_NUM-1:0] ready_vec;

	for (genvar g = 0; g < `CSA_UNIT_NUM; g++) begin : g_unit
		assign ready_vec[g] = calc[g].job_ready;
		assign calc[g].job_valid = valid_q && (cur_q == unit_idx_t'(g));
		assign calc[g].job = job_q;
	end

	assign disp_o = valid_q && ready_vec[cur_q];
	assign disp_unit_o = cur_q;
	assign disp_job_o = job_q;

	////////////////////////////////////////////////////////////
	// Read burst, round-robin scan and handshake.
	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			state_q <= ST_IDLE;
			in_ren_o <= 1'b0;
			pulse_cnt_q <= '0;
			word_cnt_q <= '0;
			take_q <= 1'b0;
			scan_q <= '0;
			cur_q <= '0;
			valid_q <= 1'b0;
		end else begin
			// Data follows its read pulse by one cycle.
			take_q <= in_ren_o;
			case (state_q)
				ST_IDLE: begin
					if (in_ready_i) begin
						in_ren_o <= 1'b1;
						pulse_cnt_q <= 3'd1;
						word_cnt_q <= '0;
						state_q <= ST_READ;
					end
				end
				ST_READ: begin
					if (pulse_cnt_q == 3'(`CSA_IN_WORDS)) begin
						in_ren_o <= 1'b0;
					end else begin
						pulse_cnt_q <= pulse_cnt_q + 1'b1;
					end
					if (take_q) begin
						word_cnt_q <= word_cnt_q + 1'b1;
						if (word_cnt_q == 3'(`CSA_IN_WORDS - 1)) begin
							state_q <= ST_SCAN;
						end
					end
				end
				ST_SCAN: begin
					if (ready_vec[scan_q]) begin
						cur_q <= scan_q;
						valid_q <= 1'b1;
						state_q <= ST_SEND;
					end
					scan_q <= (scan_q == unit_idx_t'(`CSA_UNIT_NUM - 1)) ? '0 : scan_q + 1'b1;
				end
				ST_SEND: begin
					if (ready_vec[cur_q]) begin
						valid_q <= 1'b0;
						state_q <= ST_IDLE;
					end
				end
				default: begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (state_q == ST_READ && take_q) begin
			case (word_cnt_q)
				3'd0: job_q.block <= in_rdata_i;
				3'd1: job_q.key_in[`CSA_DATA_W-1:0] <= in_rdata_i;
				3'd2: job_q.key_in[`CSA_KEY_W-1:`CSA_DATA_W] <= in_rdata_i[`CSA_KEY_W-`CSA_DATA_W-1:0];
				3'd3: job_q.times <= in_rdata_i;
				default: job_q.times_start <= in_rdata_i;
			endcase
		end
	end

	// Every read burst is exactly one job long and belongs to the read state.
	a_read_burst: assert property (@(posedge axi_mm_clk) disable iff (!rst_n)
		$rose(in_ren_o) |-> (in_ren_o && state_q == ST_READ)[*`CSA_IN_WORDS] ##1 !in_ren_o);

endmodule

/* csa_result_drain.sv */
`timescale 1ns/1ps
`include "csa_defs.svh"

module csa_result_drain
	import csa_job_pkg::*;
	import csa_reg_pkg::*;
(
	input logic axi_mm_clk,
	input logic rst_n,
	csa_calc_if.drain calc [`CSA_UNIT_NUM],
	input logic out_full_i,
	output logic out_wen_o,
	output logic [`CSA_DATA_W-1:0] out_wdata_o,
	output logic done_o,
	output unit_idx_t done_unit_o,
	output result_t done_res_o
);

	typedef enum logic {ST_SCAN, ST_WRITE} state_e;

	state_e state_q;
	unit_idx_t scan_q;
	logic [2:0] word_cnt_q;
	result_t res_q;
	logic [`CSA_UNIT_NUM-1:0] valid_vec;
	result_t res_arr [`CSA_UNIT_NUM];

	for (genvar g = 0; g < `CSA_UNIT_NUM; g++) begin : g_unit
		assign valid_vec[g] = calc[g].res_valid;
		assign res_arr[g] = calc[g].res;
		assign calc[g].res_ready = (state_q == ST_SCAN) && (scan_q == unit_idx_t'(g));
	end

	assign done_o = (state_q == ST_SCAN) && valid_vec[scan_q];
	assign done_unit_o = scan_q;
	assign done_res_o = res_arr[scan_q];

	// A word goes out only on a cycle where the FIFO has room.
	assign out_wen_o = (state_q == ST_WRITE) && !out_full_i;
	assign out_wdata_o = res_word(res_q, word_cnt_q);

	////////////////////////////////////////////////////////////
	// Round-robin poll, then one seven-word record.
	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			state_q <= ST_SCAN;
			scan_q <= '0;
			word_cnt_q <= '0;
		end else begin
			case (state_q)
				ST_SCAN: begin
					scan_q <= (scan_q == unit_idx_t'(`CSA_UNIT_NUM - 1)) ? '0 : scan_q + 1'b1;
					if (done_o) begin
						word_cnt_q <= '0;
						state_q <= ST_WRITE;
					end
				end
				default: begin
					if (out_wen_o) begin
						if (word_cnt_q == 3'(`CSA_OUT_WORDS - 1)) begin
							word_cnt_q <= '0;
							state_q <= ST_SCAN;
						end else begin
							word_cnt_q <= word_cnt_q + 1'b1;
						end
					end
				end
			endcase
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (done_o) begin
			res_q <= res_arr[scan_q];
		end
	end

	// A unit keeps its result on offer, unchanged, until the drain takes it.
	for (genvar g = 0; g < `CSA_UNIT_NUM; g++) begin : g_hold
		a_res_holds: assert property (@(posedge axi_mm_clk) disable iff (!rst_n)
			valid_vec[g] && !calc[g].res_ready |=> valid_vec[g] && $stable(res_arr[g]));
	end

endmodule

/* csa_regs.sv */
`timescale 1ns/1ps
`include "csa_defs.svh"

module csa_regs
	import csa_job_pkg::*;
	import csa_reg_pkg::*;
(
	input logic axi_mm_clk,
	input logic rst_n,
	input logic wen_i,
	input logic [`CSA_ADDR_BITS-1:0] waddr_i,
	input logic [`CSA_DATA_W-1:0] wdata_i,
	input logic ren_i,
	input logic [`CSA_ADDR_BITS-1:0] raddr_i,
	output logic [`CSA_DATA_W-1:0] rdata_o,
	input logic disp_i,
	input unit_idx_t disp_unit_i,
	input job_t disp_job_i,
	input logic done_i,
	input unit_idx_t done_unit_i,
	input result_t done_res_i
);

	unit_idx_t chan_q;
	logic chan_wr;
	snap_t in_snap_q;
	snap_t out_snap_q;
	result_t disp_res;

	assign chan_wr = wen_i && (waddr_i == CHANNEL) && (wdata_i < `CSA_UNIT_NUM);
	assign disp_res = '{calc_out: '0, job: disp_job_i};

	////////////////////////////////////////////////////////////
	// Channel and snapshots. A new channel starts with both snapshots invalid.
	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			chan_q <= '0;
			in_snap_q <= '0;
			out_snap_q <= '0;
		end else begin
			if (chan_wr) begin
				chan_q <= unit_idx_t'(wdata_i);
				in_snap_q.valid <= 1'b0;
				out_snap_q.valid <= 1'b0;
			end else begin
				if (disp_i && disp_unit_i == chan_q) begin
					in_snap_q.valid <= 1'b1;
					for (int i = 0; i < `CSA_IN_WORDS; i++) begin
						in_snap_q.words[i] <= res_word(disp_res, i);
					end
				end
				if (done_i && done_unit_i == chan_q) begin
					out_snap_q.valid <= 1'b1;
					for (int i = 0; i < `CSA_OUT_WORDS; i++) begin
						out_snap_q.words[i] <= res_word(done_res_i, i);
					end
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			rdata_o <= '0;
		end else if (ren_i) begin
			case (raddr_i)
				CHANNEL: rdata_o <= {{(`CSA_DATA_W-$bits(unit_idx_t)){1'b0}}, chan_q};
				IN_VALID: rdata_o <= {{(`CSA_DATA_W-1){1'b0}}, in_snap_q.valid};
				OUT_VALID: rdata_o <= {{(`CSA_DATA_W-1){1'b0}}, out_snap_q.valid};
				IN_DATA_0, IN_DATA_1, IN_DATA_2, IN_DATA_3, IN_DATA_4: begin
					rdata_o <= in_snap_q.words[3'(raddr_i - IN_DATA_0)];
				end
				OUT_DATA_0, OUT_DATA_1, OUT_DATA_2, OUT_DATA_3,
				OUT_DATA_4, OUT_DATA_5, OUT_DATA_6: begin
					rdata_o <= out_snap_q.words[3'(raddr_i - OUT_DATA_0)];
				end
				// Unmapped reads echo the address under an error code.
				default: rdata_o <= {16'hE000, {(16-`CSA_ADDR_BITS){1'b0}}, raddr_i};
			endcase
		end
	end

endmodule

/* csa_farm.sv */
`timescale 1ns/1ps
`include "csa_defs.svh"

module csa_farm
	import csa_job_pkg::*;
	import csa_reg_pkg::*;
(
	input logic axi_mm_clk,
	input logic rst_n,
	input logic wen_i,
	input logic [`CSA_ADDR_BITS-1:0] waddr_i,
	input logic [`CSA_DATA_W-1:0] wdata_i,
	input logic ren_i,
	input logic [`CSA_ADDR_BITS-1:0] raddr_i,
	output logic [`CSA_DATA_W-1:0] rdata_o,
	input logic in_ready_i,
	output logic in_ren_o,
	input logic [`CSA_DATA_W-1:0] in_rdata_i,
	input logic out_full_i,
	output logic out_wen_o,
	output logic [`CSA_DATA_W-1:0] out_wdata_o
);

	logic disp;
	unit_idx_t disp_unit;
	job_t disp_job;
	logic done;
	unit_idx_t done_unit;
	result_t done_res;

	csa_calc_if calc [`CSA_UNIT_NUM] ();

	for (genvar g = 0; g < `CSA_UNIT_NUM; g++) begin : g_unit
		csa_calc_unit u_calc_unit (
			.axi_mm_clk(axi_mm_clk),
			.rst_n(rst_n),
			.calc(calc[g])
		);
	end

	csa_job_loader u_job_loader (
		.axi_mm_clk(axi_mm_clk),
		.rst_n(rst_n),
		.in_ready_i(in_ready_i),
		.in_ren_o(in_ren_o),
		.in_rdata_i(in_rdata_i),
		.calc(calc),
		.disp_o(disp),
		.disp_unit_o(disp_unit),
		.disp_job_o(disp_job)
	);

	csa_result_drain u_result_drain (
		.axi_mm_clk(axi_mm_clk),
		.rst_n(rst_n),
		.calc(calc),
		.out_full_i(out_full_i),
		.out_wen_o(out_wen_o),
		.out_wdata_o(out_wdata_o),
		.done_o(done),
		.done_unit_o(done_unit),
		.done_res_o(done_res)
	);

	csa_regs u_regs (
		.axi_mm_clk(axi_mm_clk),
		.rst_n(rst_n),
		.wen_i(wen_i),
		.waddr_i(waddr_i),
		.wdata_i(wdata_i),
		.ren_i(ren_i),
		.raddr_i(raddr_i),
		.rdata_o(rdata_o),
		.disp_i(disp),
		.disp_unit_i(disp_unit),
		.disp_job_i(disp_job),
		.done_i(done),
		.done_unit_i(done_unit),
		.done_res_i(done_res)
	);

endmodule

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS = 20,
	parameter int RESET_CYCLES = 4
) (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

	// Reset is released on a falling edge, like every other input of the DUT.
	initial begin
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		rst_n_o = 1'b1;
	end

endmodule

/* tb_csa_farm.sv */
`timescale 1ns/1ps
`include "csa_defs.svh"

module tb_csa_farm
	import csa_reg_pkg::*;
();

	localparam int JOB_NUM = 40;
	localparam int SEQ_JOBS = 8;
	localparam int MAX_TIMES = 15;
	localparam int WATCH_UNIT = 2;
	localparam int ADDR_W = `CSA_ADDR_BITS;
	localparam int CYCLE_LIMIT = JOB_NUM * (20 + `CSA_OUT_WORDS + MAX_TIMES) * 4;
	localparam int FULL_LEN = 1024;
	localparam logic [31:0] SEED = 32'h5d1b3c87;

	logic axi_mm_clk;
	logic rst_n;
	logic wen_i;
	logic [ADDR_W-1:0] waddr_i;
	logic [`CSA_DATA_W-1:0] wdata_i;
	logic ren_i;
	logic [ADDR_W-1:0] raddr_i;
	logic [`CSA_DATA_W-1:0] rdata_o;
	logic in_ready_i;
	logic in_ren_o;
	logic [`CSA_DATA_W-1:0] in_rdata_i;
	logic out_full_i;
	logic out_wen_o;
	logic [`CSA_DATA_W-1:0] out_wdata_o;

	logic [31:0] job_w [JOB_NUM][`CSA_IN_WORDS];
	logic [31:0] exp_w [JOB_NUM][`CSA_OUT_WORDS];
	logic [31:0] rec_buf [`CSA_OUT_WORDS];
	logic [31:0] snap_w [`CSA_OUT_WORDS];
	logic queued [JOB_NUM];
	logic seen [JOB_NUM];
	logic full_pat [FULL_LEN];
	logic [31:0] in_q [$];
	int unsigned recs_done = 0;
	int unsigned check_cnt = 0;
	int unsigned error_cnt = 0;
	int unsigned cycle_cnt = 0;

	tb_clock u_clock (
		.clk_o(axi_mm_clk),
		.rst_n_o(rst_n)
	);

	csa_farm u_csa_farm (
		.axi_mm_clk(axi_mm_clk),
		.rst_n(rst_n),
		.wen_i(wen_i),
		.waddr_i(waddr_i),
		.wdata_i(wdata_i),
		.ren_i(ren_i),
		.raddr_i(raddr_i),
		.rdata_o(rdata_o),
		.in_ready_i(in_ready_i),
		.in_ren_o(in_ren_o),
		.in_rdata_i(in_rdata_i),
		.out_full_i(out_full_i),
		.out_wen_o(out_wen_o),
		.out_wdata_o(out_wdata_o)
	);

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		check_cnt++;
		if (got !== exp) begin
			error_cnt++;
			$display("ERROR %s: got %08h, expected %08h", name, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int unsigned mark);
		$display("test %s finished with %0d errors", name, error_cnt - mark);
	endtask

	// Reference of the mixing rule, one rotate and XOR per round.
	function automatic logic [63:0] mix_model(input logic [31:0] block, input logic [47:0] key,
		input logic [31:0] times, input logic [31:0] start);
		logic [63:0] s;
		s = {16'h0, key} ^ {block, block};
		for (int unsigned k = 0; k < times; k++) begin
			s = {s[62:0], s[63]} ^ {32'h0, start + k};
		end
		return s;
	endfunction

	task automatic make_stimulus();
		logic [47:0] key;
		logic [63:0] st;
		for (int j = 0; j < JOB_NUM; j++) begin
			// The job number in the top byte makes every block unique.
			job_w[j][0] = {8'(j), 24'($urandom)};
			job_w[j][1] = $urandom;
			job_w[j][2] = $urandom;
			job_w[j][3] = $urandom % (MAX_TIMES + 1);
			job_w[j][4] = $urandom;
			key = {job_w[j][2][15:0], job_w[j][1]};
			st = mix_model(job_w[j][0], key, job_w[j][3], job_w[j][4]);
			exp_w[j][0] = job_w[j][0];
			exp_w[j][1] = job_w[j][1];
			exp_w[j][2] = {16'h0, job_w[j][2][15:0]};
			exp_w[j][3] = job_w[j][3];
			exp_w[j][4] = job_w[j][4];
			exp_w[j][5] = st[31:0];
			exp_w[j][6] = st[63:32];
			queued[j] = 1'b0;
			seen[j] = 1'b0;
		end
		for (int i = 0; i < FULL_LEN; i++) begin
			full_pat[i] = ($urandom % 4) == 0;
		end
	endtask

	task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [31:0] data);
		@(negedge axi_mm_clk);
		wen_i = 1'b1;
		waddr_i = addr;
		wdata_i = data;
		@(negedge axi_mm_clk);
		wen_i = 1'b0;
	endtask

	task automatic read_reg(input logic [ADDR_W-1:0] addr, output logic [31:0] data);
		@(negedge axi_mm_clk);
		ren_i = 1'b1;
		raddr_i = addr;
		@(negedge axi_mm_clk);
		ren_i = 1'b0;
		data = rdata_o;
	endtask

	task automatic push_job(input int j);
		@(posedge axi_mm_clk);
		for (int w = 0; w < `CSA_IN_WORDS; w++) begin
			in_q.push_back(job_w[j][w]);
		end
		queued[j] = 1'b1;
	endtask

	// Reads n snapshot words and matches them to job want, or to any job when want is negative.
	task automatic check_snapshot(input logic [ADDR_W-1:0] base, input int n, input int want,
		input string tag);
		logic [31:0] rd;
		int unsigned jn;
		for (int i = 0; i < n; i++) begin
			read_reg(ADDR_W'(base + i), rd);
			snap_w[i] = rd;
		end
		jn = (want >= 0) ? want : snap_w[0][31:24];
		if (jn >= JOB_NUM) begin
			error_cnt++;
			$display("Snapshot %s holds block %08h, which belongs to no job.", tag, snap_w[0]);
		end else begin
			for (int i = 0; i < n; i++) begin
				check_value($sformatf("rdata_o %s word %0d", tag, i), snap_w[i], exp_w[jn][i]);
			end
		end
	endtask

	task automatic match_record();
		int unsigned jn;
		jn = rec_buf[0][31:24];
		if (jn >= JOB_NUM || !queued[jn] || seen[jn]) begin
			error_cnt++;
			$display("Output record with block %08h matches no outstanding job.", rec_buf[0]);
		end else begin
			seen[jn] = 1'b1;
			for (int w = 0; w < `CSA_OUT_WORDS; w++) begin
				check_value($sformatf("out_wdata_o job %0d word %0d", jn, w), rec_buf[w],
					exp_w[jn][w]);
			end
		end
		recs_done++;
	endtask

	////////////////////////////////////////////////////////////
	// Input FIFO model. A word appears one cycle after its read pulse.
	initial begin
		logic ren_prev;
		in_ready_i = 1'b0;
		in_rdata_i = '0;
		ren_prev = 1'b0;
		forever begin
			@(negedge axi_mm_clk);
			if (ren_prev) begin
				if (in_q.size() == 0) begin
					error_cnt++;
					$display("The loader read the input FIFO while it was empty.");
				end else begin
					in_rdata_i = in_q.pop_front();
				end
			end
			ren_prev = (in_ren_o === 1'b1);
			in_ready_i = (in_q.size() >= `CSA_IN_WORDS);
		end
	end

	// Output FIFO model with a random full flag.
	initial begin
		int unsigned idx;
		int unsigned word_idx;
		out_full_i = 1'b0;
		idx = 0;
		word_idx = 0;
		forever begin
			@(negedge axi_mm_clk);
			if (rst_n !== 1'b1) begin
				out_full_i = 1'b0;
			end else begin
				out_full_i = full_pat[idx % FULL_LEN];
				idx++;
			end
			// out_wen_o follows out_full_i and then holds until the next rising edge.
			#1;
			if (out_wen_o === 1'b1) begin
				if (out_full_i) begin
					error_cnt++;
					$display("A word was written to the output FIFO while it was full.");
				end
				rec_buf[word_idx] = out_wdata_o;
				word_idx++;
				if (word_idx == `CSA_OUT_WORDS) begin
					match_record();
					word_idx = 0;
				end
			end
		end
	end

	always @(posedge axi_mm_clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, only %0d of %0d records came out.",
				cycle_cnt, recs_done, JOB_NUM);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	initial begin
		logic [31:0] rd;
		int unsigned err_mark;
		int last_job;
		wen_i = 1'b0;
		waddr_i = '0;
		wdata_i = '0;
		ren_i = 1'b0;
		raddr_i = '0;
		void'($urandom(SEED));
		make_stimulus();
		wait (rst_n === 1'b1);

		err_mark = error_cnt;
		check_value("in_ren_o", 32'(in_ren_o), 32'h0);
		check_value("out_wen_o", 32'(out_wen_o), 32'h0);
		read_reg(CHANNEL, rd);
		check_value("rdata_o CHANNEL", rd, 32'h0);
		report_test("reset_state", err_mark);

		err_mark = error_cnt;
		write_reg(CHANNEL, 32'd2);
		read_reg(CHANNEL, rd);
		check_value("rdata_o CHANNEL", rd, 32'd2);
		write_reg(CHANNEL, 32'd7);
		read_reg(CHANNEL, rd);
		check_value("rdata_o CHANNEL", rd, 32'd2);
		report_test("channel_write", err_mark);

		// With one job in flight every unit is free, so job j lands on unit j mod 4.
		err_mark = error_cnt;
		last_job = 0;
		for (int j = 0; j < SEQ_JOBS; j++) begin
			push_job(j);
			while (recs_done < j + 1) @(negedge axi_mm_clk);
			if (j % `CSA_UNIT_NUM == WATCH_UNIT) begin
				last_job = j;
			end
		end
		read_reg(IN_VALID, rd);
		check_value("rdata_o IN_VALID", rd, 32'h1);
		read_reg(OUT_VALID, rd);
		check_value("rdata_o OUT_VALID", rd, 32'h1);
		check_snapshot(IN_DATA_0, `CSA_IN_WORDS, last_job, "IN_DATA");
		check_snapshot(OUT_DATA_0, `CSA_OUT_WORDS, last_job, "OUT_DATA");
		report_test("single_jobs", err_mark);

		// Both snapshots are valid here, and selecting the channel again drops them.
		err_mark = error_cnt;
		write_reg(CHANNEL, 32'd2);
		read_reg(IN_VALID, rd);
		check_value("rdata_o IN_VALID", rd, 32'h0);
		read_reg(OUT_VALID, rd);
		check_value("rdata_o OUT_VALID", rd, 32'h0);
		report_test("channel_clear", err_mark);

		err_mark = error_cnt;
		for (int j = SEQ_JOBS; j < JOB_NUM; j++) begin
			push_job(j);
		end
		while (recs_done < JOB_NUM) @(negedge axi_mm_clk);
		for (int j = 0; j < JOB_NUM; j++) begin
			check_value($sformatf("record seen for job %0d", j), 32'(seen[j]), 32'h1);
		end
		check_value("input FIFO words left", 32'(in_q.size()), 32'h0);
		report_test("random_jobs", err_mark);

		err_mark = error_cnt;
		read_reg(IN_VALID, rd);
		check_value("rdata_o IN_VALID", rd, 32'h1);
		read_reg(OUT_VALID, rd);
		check_value("rdata_o OUT_VALID", rd, 32'h1);
		check_snapshot(IN_DATA_0, `CSA_IN_WORDS, -1, "IN_DATA");
		check_snapshot(OUT_DATA_0, `CSA_OUT_WORDS, -1, "OUT_DATA");
		report_test("channel_snapshot", err_mark);

		err_mark = error_cnt;
		read_reg(ADDR_W'(100), rd);
		check_value("rdata_o unmapped", rd, 32'hE0000064);
		report_test("unmapped_read", err_mark);

		$display("checks: %0d, errors: %0d", check_cnt, error_cnt);
		if (error_cnt == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

/* verilog.f */
+incdir+.
csa_job_pkg.sv
csa_reg_pkg.sv
csa_calc_if.sv
csa_slot.sv
csa_calc_unit.sv
csa_job_loader.sv
csa_result_drain.sv
csa_regs.sv
csa_farm.sv
tb_clock.sv
tb_csa_farm.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_csa_farm
FILELIST   := verilog.f
BUILD_DIR  := obj_dir
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
